// File: hw/rv32i_pipe_pkg.sv
package rv32i_pipe_pkg;

    // ------------------------------
    // Widths and constants
    // ------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int PC_STEP    = 4;

    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [REG_ADDR_W-1:0] UART_REG = 5'd10;      // a0 shown on uart_data

    // ------------------------------
    // Encodings
    // ------------------------------
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // Values follow funct3 of the B format
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_NONE = 3'b010,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_op_e;

    typedef enum logic {
        SRC_REG = 1'b0,
        SRC_IMM = 1'b1
    } alu_src_e;

endpackage

// File: hw/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             branch_taken,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]  branch_target_pc,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]  mmu_data_out,
    output logic [rv32i_pipe_pkg::XLEN-1:0]  mmu_address,
    output logic [rv32i_pipe_pkg::XLEN-1:0]  ifid_pc,
    output logic [rv32i_pipe_pkg::XLEN-1:0]  ifid_ir
);
    import rv32i_pipe_pkg::*;

    logic [XLEN-1:0] pc;

    assign mmu_address = pc;  // Word comes back in the same cycle

    // PC and IF/ID instruction
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc      <= '0;
            ifid_ir <= NOP_INSTR;
        end else begin
            pc      <= branch_taken ? branch_target_pc : pc + XLEN'(PC_STEP);
            ifid_ir <= branch_taken ? NOP_INSTR : mmu_data_out;  // Squash wrong-path fetch
        end
    end

    always_ff @(posedge clk) begin
        ifid_pc <= pc;
    end

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  logic                                   branch_taken,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]        ifid_pc,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]        ifid_ir,
    output logic [rv32i_pipe_pkg::REG_ADDR_W-1:0]  rs1_addr,
    output logic [rv32i_pipe_pkg::REG_ADDR_W-1:0]  rs2_addr,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]        rs1_data,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]        rs2_data,
    output logic [rv32i_pipe_pkg::XLEN-1:0]        idex_pc,
    output logic [rv32i_pipe_pkg::XLEN-1:0]        idex_imm,
    output logic [rv32i_pipe_pkg::XLEN-1:0]        idex_data_1,
    output logic [rv32i_pipe_pkg::XLEN-1:0]        idex_data_2,
    output logic [rv32i_pipe_pkg::REG_ADDR_W-1:0]  idex_rs1,
    output logic [rv32i_pipe_pkg::REG_ADDR_W-1:0]  idex_rs2,
    output logic [rv32i_pipe_pkg::REG_ADDR_W-1:0]  idex_rd,
    output rv32i_pipe_pkg::alu_op_e                idex_alu_op,
    output rv32i_pipe_pkg::alu_src_e               idex_alu_src,
    output rv32i_pipe_pkg::branch_op_e             idex_branch_op,
    output logic                                   idex_reg_write
);
    import rv32i_pipe_pkg::*;

    // ------------------------------
    // Field extraction
    // ------------------------------
    logic [6:0]      funct7;
    logic [2:0]      funct3;
    logic [XLEN-1:0] i_imm;
    logic [XLEN-1:0] shamt_imm;
    logic [XLEN-1:0] b_imm;

    assign funct7   = ifid_ir[31:25];
    assign funct3   = ifid_ir[14:12];
    assign rs1_addr = ifid_ir[19:15];
    assign rs2_addr = ifid_ir[24:20];

    assign i_imm     = {{20{ifid_ir[31]}}, ifid_ir[31:20]};
    assign shamt_imm = {27'b0, ifid_ir[24:20]};
    assign b_imm     = {{19{ifid_ir[31]}}, ifid_ir[31], ifid_ir[7],
                        ifid_ir[30:25], ifid_ir[11:8], 1'b0};

    // ------------------------------
    // Control decode
    // ------------------------------
    alu_op_e         dec_alu_op;
    alu_src_e        dec_alu_src;
    branch_op_e      dec_branch_op;
    logic            dec_reg_write;
    logic [XLEN-1:0] dec_imm;

    always_comb begin
        dec_alu_op    = ALU_ADD;
        dec_alu_src   = SRC_REG;
        dec_branch_op = BR_NONE;
        dec_reg_write = 1'b0;  // Bubble unless recognised
        dec_imm       = i_imm;
        case (opcode_e'(ifid_ir[6:0]))
            OPC_OP: begin
                dec_reg_write = 1'b1;
                case (funct3)
                    3'b000:  dec_alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001:  dec_alu_op = ALU_SLL;
                    3'b010:  dec_alu_op = ALU_SLT;
                    3'b011:  dec_alu_op = ALU_SLTU;
                    3'b100:  dec_alu_op = ALU_XOR;
                    3'b101:  dec_alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  dec_alu_op = ALU_OR;
                    default: dec_alu_op = ALU_AND;
                endcase
            end
            OPC_OP_IMM: begin
                dec_reg_write = 1'b1;
                dec_alu_src   = SRC_IMM;
                case (funct3)
                    3'b000:  dec_alu_op = ALU_ADD;
                    3'b010:  dec_alu_op = ALU_SLT;
                    3'b011:  dec_alu_op = ALU_SLTU;
                    3'b100:  dec_alu_op = ALU_XOR;
                    3'b110:  dec_alu_op = ALU_OR;
                    3'b111:  dec_alu_op = ALU_AND;
                    3'b001: begin
                        dec_alu_op = ALU_SLL;
                        dec_imm    = shamt_imm;
                    end
                    default: begin
                        dec_alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                        dec_imm    = shamt_imm;
                    end
                endcase
            end
            OPC_BRANCH: begin
                dec_imm = b_imm;
                case (branch_op_e'(funct3))
                    BR_BEQ, BR_BNE:   dec_alu_op = ALU_SUB;   // Zero test
                    BR_BLT, BR_BGE:   dec_alu_op = ALU_SLT;
                    BR_BLTU, BR_BGEU: dec_alu_op = ALU_SLTU;
                    default:          dec_alu_op = ALU_ADD;
                endcase
                if (funct3[2:1] != 2'b01) begin
                    dec_branch_op = branch_op_e'(funct3);
                end
            end
            default: ;
        endcase
    end

    // ------------------------------
    // ID/EX register
    // ------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idex_alu_op    <= ALU_ADD;
            idex_alu_src   <= SRC_REG;
            idex_branch_op <= BR_NONE;
            idex_reg_write <= 1'b0;
        end else begin
            idex_alu_op    <= dec_alu_op;
            idex_alu_src   <= dec_alu_src;
            idex_branch_op <= branch_taken ? BR_NONE : dec_branch_op;
            idex_reg_write <= dec_reg_write & ~branch_taken;
        end
    end

    always_ff @(posedge clk) begin
        idex_pc     <= ifid_pc;
        idex_imm    <= dec_imm;
        idex_data_1 <= rs1_data;
        idex_data_2 <= rs2_data;
        idex_rs1    <= rs1_addr;
        idex_rs2    <= rs2_addr;
        idex_rd     <= ifid_ir[11:7];
    end

endmodule

// File: hw/register_file.sv
`timescale 1ns/10ps

module register_file (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  logic [rv32i_pipe_pkg::REG_ADDR_W-1:0]  rs1_addr,
    input  logic [rv32i_pipe_pkg::REG_ADDR_W-1:0]  rs2_addr,
    input  logic [rv32i_pipe_pkg::REG_ADDR_W-1:0]  write_addr,
    input  logic                                   write_enable,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]        write_data,
    output logic [rv32i_pipe_pkg::XLEN-1:0]        rs1_data,
    output logic [rv32i_pipe_pkg::XLEN-1:0]        rs2_data,
    output logic [rv32i_pipe_pkg::XLEN-1:0]        uart_data
);
    import rv32i_pipe_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    // Same-cycle write wins over stored value
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;  // x0 hard zero
        end else if (write_enable && addr == write_addr) begin
            return write_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data  = read_port(rs1_addr);
        rs2_data  = read_port(rs2_addr);
        uart_data = read_port(UART_REG);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_addr != '0) begin
            regs[write_addr] <= write_data;
        end
    end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  logic                                   branch_taken,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]        idex_pc,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]        idex_imm,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]        idex_data_1,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]        idex_data_2,
    input  logic [rv32i_pipe_pkg::REG_ADDR_W-1:0]  idex_rs1,
    input  logic [rv32i_pipe_pkg::REG_ADDR_W-1:0]  idex_rs2,
    input  logic [rv32i_pipe_pkg::REG_ADDR_W-1:0]  idex_rd,
    input  rv32i_pipe_pkg::alu_op_e                idex_alu_op,
    input  rv32i_pipe_pkg::alu_src_e               idex_alu_src,
    input  rv32i_pipe_pkg::branch_op_e             idex_branch_op,
    input  logic                                   idex_reg_write,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]        memwb_alu_out,
    input  logic [rv32i_pipe_pkg::REG_ADDR_W-1:0]  memwb_rd,
    input  logic                                   memwb_reg_write,
    output logic [rv32i_pipe_pkg::XLEN-1:0]        exmem_alu_out,
    output logic [rv32i_pipe_pkg::XLEN-1:0]        exmem_branch_target,
    output rv32i_pipe_pkg::branch_op_e             exmem_branch_op,
    output logic [rv32i_pipe_pkg::REG_ADDR_W-1:0]  exmem_rd,
    output logic                                   exmem_reg_write
);
    import rv32i_pipe_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;

    // ------------------------------
    // Forwarding
    // ------------------------------
    // Youngest producer first
    function automatic logic [XLEN-1:0] fwd(input logic [REG_ADDR_W-1:0] rs,
                                            input logic [XLEN-1:0] reg_val);
        if (exmem_reg_write && exmem_rd != '0 && exmem_rd == rs) begin
            return exmem_alu_out;
        end else if (memwb_reg_write && memwb_rd != '0 && memwb_rd == rs) begin
            return memwb_alu_out;
        end
        return reg_val;
    endfunction

    always_comb begin
        op_a = fwd(idex_rs1, idex_data_1);
        op_b = (idex_alu_src == SRC_IMM) ? idex_imm : fwd(idex_rs2, idex_data_2);
    end

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb begin
        case (idex_alu_op)
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_SLL:  alu_out = op_a << op_b[4:0];
            ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_SRL:  alu_out = op_a >> op_b[4:0];
            ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
            ALU_OR:   alu_out = op_a | op_b;
            ALU_AND:  alu_out = op_a & op_b;
            default:  alu_out = op_a + op_b;
        endcase
    end

    // EX/MEM register takes a bubble on redirect
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exmem_branch_op <= BR_NONE;
            exmem_reg_write <= 1'b0;
        end else begin
            exmem_branch_op <= branch_taken ? BR_NONE : idex_branch_op;
            exmem_reg_write <= idex_reg_write & ~branch_taken;
        end
    end

    always_ff @(posedge clk) begin
        exmem_alu_out       <= alu_out;
        exmem_branch_target <= idex_pc + idex_imm;  // B immediate relative to branch PC
        exmem_rd            <= idex_rd;
    end

endmodule

// File: hw/memory_stage.sv
`timescale 1ns/10ps

module memory_stage (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]        exmem_alu_out,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]        exmem_branch_target,
    input  rv32i_pipe_pkg::branch_op_e             exmem_branch_op,
    input  logic [rv32i_pipe_pkg::REG_ADDR_W-1:0]  exmem_rd,
    input  logic                                   exmem_reg_write,
    output logic                                   branch_taken,
    output logic [rv32i_pipe_pkg::XLEN-1:0]        branch_target_pc,
    output logic [rv32i_pipe_pkg::XLEN-1:0]        memwb_alu_out,
    output logic [rv32i_pipe_pkg::REG_ADDR_W-1:0]  memwb_rd,
    output logic                                   memwb_reg_write
);
    import rv32i_pipe_pkg::*;

    logic alu_zero;

    assign alu_zero         = (exmem_alu_out == '0);
    assign branch_target_pc = exmem_branch_target;

    // ------------------------------
    // Branch decision
    // ------------------------------
    always_comb begin
        case (exmem_branch_op)
            BR_BEQ:           branch_taken = alu_zero;
            BR_BNE:           branch_taken = ~alu_zero;
            BR_BLT, BR_BLTU:  branch_taken = exmem_alu_out[0];  // Compare result is 0 or 1
            BR_BGE, BR_BGEU:  branch_taken = alu_zero;
            default:          branch_taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            memwb_reg_write <= 1'b0;
        end else begin
            memwb_reg_write <= exmem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        memwb_alu_out <= exmem_alu_out;
        memwb_rd      <= exmem_rd;
    end

endmodule

// File: hw/rv32i_pipe.sv
`timescale 1ns/10ps

module rv32i_pipe (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]  mmu_data_out,
    output logic [rv32i_pipe_pkg::XLEN-1:0]  mmu_address,
    output logic [rv32i_pipe_pkg::XLEN-1:0]  uart_data
);
    import rv32i_pipe_pkg::*;

    // ------------------------------
    // Stage boundaries
    // ------------------------------
    logic [XLEN-1:0]       ifid_pc, ifid_ir;
    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic [XLEN-1:0]       rs1_data, rs2_data;

    logic [XLEN-1:0]       idex_pc, idex_imm, idex_data_1, idex_data_2;
    logic [REG_ADDR_W-1:0] idex_rs1, idex_rs2, idex_rd;
    alu_op_e               idex_alu_op;
    alu_src_e              idex_alu_src;
    branch_op_e            idex_branch_op;
    logic                  idex_reg_write;

    logic [XLEN-1:0]       exmem_alu_out, exmem_branch_target;
    branch_op_e            exmem_branch_op;
    logic [REG_ADDR_W-1:0] exmem_rd;
    logic                  exmem_reg_write;

    logic                  branch_taken;
    logic [XLEN-1:0]       branch_target_pc;
    logic [XLEN-1:0]       memwb_alu_out;
    logic [REG_ADDR_W-1:0] memwb_rd;
    logic                  memwb_reg_write;

    fetch_stage i_fetch (.*);

    decode_stage i_decode (.*);

    // Writeback goes straight from MEM/WB
    register_file i_register_file (
        .clk          (clk),
        .reset_n      (reset_n),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .write_addr   (memwb_rd),
        .write_enable (memwb_reg_write),
        .write_data   (memwb_alu_out),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .uart_data    (uart_data)
    );

    execute_stage i_execute (.*);

    memory_stage i_memory (.*);

endmodule

// File: sim/tb_rv32i_pipe.sv
`timescale 1ns/10ps

module tb_rv32i_pipe;
    import rv32i_pipe_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 4;
    localparam int MARGIN_CYCLES = 20;   // Per test for reset and drain
    localparam int DATA_WORDS    = 256;

    logic            clk;
    logic            reset_n;
    logic [XLEN-1:0] mmu_data_out;
    logic [XLEN-1:0] mmu_address;
    logic [XLEN-1:0] uart_data;

    logic [31:0] test_data [DATA_WORDS];
    logic [31:0] prog [DATA_WORDS];
    int          prog_len;
    int          test_idx;
    int          checks;
    int          errors;
    int          timeout_ns;

    rv32i_pipe i_rv32i_pipe (
        .clk          (clk),
        .reset_n      (reset_n),
        .mmu_data_out (mmu_data_out),
        .mmu_address  (mmu_address),
        .uart_data    (uart_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // Instruction memory model
    // ------------------------------
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr[1:0] != 2'b00 || (addr >> 2) >= prog_len) begin
            return NOP_INSTR;  // Past the end of the program
        end
        return prog[addr >> 2];
    endfunction

    // Sign-extended B-type immediate
    function automatic logic [31:0] b_offset(input logic [31:0] instr);
        return {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    endfunction

    always @(negedge clk) begin
        mmu_data_out <= fetch_word(mmu_address);
    end

    // ------------------------------
    // Checks and sequencing
    // ------------------------------
    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("** Error: %s expected %08h, got %08h (test %0d, %0t)",
                 name, expected, actual, test_idx, $time);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset_n = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            checks += 2;
            if (mmu_address !== 32'h0) begin
                report_mismatch("mmu_address", 32'h0, mmu_address);
            end
            if (uart_data !== 32'h0) begin
                report_mismatch("uart_data", 32'h0, uart_data);
            end
        end
        reset_n = 1'b1;  // PC 0 is fetched at the next rising edge
    endtask

    // Samples the fetch address once per cycle
    task automatic run_program(input int cycles);
        int          due_q[$];
        logic [31:0] target_q[$];
        logic [31:0] prev_addr;
        logic [31:0] word;
        prev_addr = 32'h0;
        for (int cyc = 0; cyc < cycles; cyc++) begin
            if (cyc > 0) begin
                @(negedge clk);
                checks++;
                if (due_q.size() > 0 && due_q[0] == cyc) begin
                    // Branch fetched four cycles ago
                    if (mmu_address !== target_q[0] && mmu_address !== prev_addr + 32'd4) begin
                        report_mismatch("mmu_address", target_q[0], mmu_address);
                    end
                    if (mmu_address === target_q[0] && target_q[0] != prev_addr + 32'd4) begin
                        due_q.delete();     // Younger fetches squashed
                        target_q.delete();
                    end else begin
                        due_q.delete(0);
                        target_q.delete(0);
                    end
                end else if (mmu_address !== prev_addr + 32'd4) begin
                    report_mismatch("mmu_address", prev_addr + 32'd4, mmu_address);
                end
            end
            word = fetch_word(mmu_address);
            if (word[6:0] == 7'b1100011) begin  // Conditional branch
                due_q.push_back(cyc + 4);
                target_q.push_back(mmu_address + b_offset(word));
            end
            prev_addr = mmu_address;
        end
    endtask

    initial begin
        int          ptr;
        int          num_tests;
        int          total_cycles;
        int          run_cycles;
        logic [31:0] expected_x10;

        reset_n      = 1'b0;
        mmu_data_out = NOP_INSTR;
        prog_len     = 0;
        test_idx     = 0;
        checks       = 0;
        errors       = 0;
        timeout_ns   = 0;

        $readmemh("sim/rv32i_pipe_tests.txt", test_data);
        num_tests    = int'(test_data[0]);
        total_cycles = int'(test_data[1]);
        timeout_ns   = (total_cycles + MARGIN_CYCLES * num_tests) * CLK_PERIOD;
        if (num_tests <= 0) begin
            errors++;
            $display("No tests could be read from the data file");
        end

        ptr = 2;
        for (test_idx = 0; test_idx < num_tests; test_idx++) begin
            prog_len     = int'(test_data[ptr]);
            run_cycles   = int'(test_data[ptr + 1]);
            expected_x10 = test_data[ptr + 2];
            ptr += 3;
            for (int i = 0; i < prog_len; i++) begin
                prog[i] = test_data[ptr + i];
            end
            ptr += prog_len;
            $display("Test %0d: %0d words, %0d cycles", test_idx, prog_len, run_cycles);

            apply_reset();
            run_program(run_cycles);
            checks++;
            if (uart_data !== expected_x10) begin
                report_mismatch("uart_data", expected_x10, uart_data);
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog armed once the data file is read
    initial begin
        wait (timeout_ns > 0);
        #(timeout_ns);
        $display("Timeout: the tests did not complete within %0d ns", timeout_ns);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: rv32i_pipe.f
hw/rv32i_pipe_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/register_file.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/rv32i_pipe.sv
sim/tb_rv32i_pipe.sv

// File: Bender.yml
package:
  name: rv32i_pipe

sources:
  - hw/rv32i_pipe_pkg.sv
  - hw/fetch_stage.sv
  - hw/decode_stage.sv
  - hw/register_file.sv
  - hw/execute_stage.sv
  - hw/memory_stage.sv
  - hw/rv32i_pipe.sv
  - target: simulation
    files:
      - sim/tb_rv32i_pipe.sv

// File: sim/rv32i_pipe_tests.txt
// Header line: number of tests, total cycles over all tests
// Each test: word count, cycles to run, expected x10; then the instruction words (all hex)
5 6B
// Immediate ALU ops, srai of a negative value, slti against sltiu
B 11 0000010D
FF000093 4020D113 01C0D193 00419213 0FF24293 3002E513 1FC57513 FFD12193
00513213 00350533 00450533
// Register-register ALU ops
D 13 00000A21
12300093 FFE00113 00300193 40308233 003212B3 40315233 0032D0B3 001221B3
00123533 00556533 00354533 00457533 00150533
// Operands at distances 1, 2 and 3, EX/MEM result ahead of MEM/WB
8 E 0000002A
00500093 00700113 00900193 00308233 004102B3 40428533 00450533 00A50533
// Six taken branches, each jumping over four increments of x10
22 24 00000155
FFF00093 00100113 05500513 00210A63 00150513 00150513 00150513 00150513
00209A63 00150513 00150513 00150513 00150513 0020CA63 00150513 00150513
00150513 00150513 00115A63 00150513 00150513 00150513 00150513 00116A63
00150513 00150513 00150513 00150513 0020FA63 00150513 00150513 00150513
00150513 10050513
// Six not-taken branches, each followed by one increment
F 15 0000005B
FFF00093 00100113 05500513 00208463 00150513 00211463 00150513 00114463
00150513 0020D463 00150513 0020E463 00150513 00117463 00150513
